/* Bender.yml */
package:
  name: l2_mem_subsys

sources:
  - include_dirs:
      - hw
    files:
      - hw/l2_axil_pkg.sv
      - hw/l2_mem_pkg.sv
      - hw/l2_bank_if.sv
      - hw/l2_sram_bank.sv
      - hw/l2_ram_multi_bank.sv
      - hw/l2_init_counter.sv
      - hw/l2_bank_router.sv
      - hw/l2_axil_ctrl.sv
      - hw/l2_mem_subsys.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/tb_l2_mem_subsys.sv

/* hw/l2_axil_ctrl.sv */
// AXI4-Lite slave FSM, keeps the port closed during zeroing and turns each transaction into one bank request
`timescale 1ns/1ps

module l2_axil_ctrl #(
   parameter int unsigned IDX_W  = 6,
   parameter int unsigned DATA_W = 32
) (
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  logic                  init_done_i,
   input  logic [IDX_W-1:0]      init_index_i,
   input  logic                  awvalid_i,
   output logic                  awready_o,
   input  logic [31:0]           awaddr_i,
   input  logic                  wvalid_i,
   output logic                  wready_o,
   input  logic [DATA_W-1:0]     wdata_i,
   input  logic [DATA_W/8-1:0]   wstrb_i,
   output logic                  bvalid_o,
   input  logic                  bready_i,
   output logic [1:0]            bresp_o,
   input  logic                  arvalid_i,
   output logic                  arready_o,
   input  logic [31:0]           araddr_i,
   output logic                  rvalid_o,
   input  logic                  rready_i,
   output logic [DATA_W-1:0]     rdata_o,
   output logic [1:0]            rresp_o,
   l2_bank_if.master             bank_o,
   output logic                  broadcast_o,
   input  logic                  resp_err_i
);

   l2_axil_pkg::ctrl_state_e state_q, state_d;
   l2_axil_pkg::axil_resp_e  resp_q;
   logic [31:0]              addr_q;
   logic [DATA_W-1:0]        wdata_q;
   logic [DATA_W/8-1:0]      wstrb_q;
   logic [DATA_W-1:0]        rdata_q;
   logic                     wr_acc;
   logic                     rd_acc;
   logic                     in_init;

   assign in_init = (state_q == l2_axil_pkg::ST_INIT);

   // Write needs both address and data, and wins over a read in the same cycle
   assign wr_acc = (state_q == l2_axil_pkg::ST_IDLE) && awvalid_i && wvalid_i;
   assign rd_acc = (state_q == l2_axil_pkg::ST_IDLE) && arvalid_i && !(awvalid_i && wvalid_i);

   assign awready_o = wr_acc;
   assign wready_o  = wr_acc;
   assign arready_o = rd_acc;

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         l2_axil_pkg::ST_INIT:    if (init_done_i) state_d = l2_axil_pkg::ST_IDLE;
         l2_axil_pkg::ST_IDLE: begin
            if (wr_acc) begin
               state_d = l2_axil_pkg::ST_WR_REQ;
            end else if (rd_acc) begin
               state_d = l2_axil_pkg::ST_RD_REQ;
            end
         end
         l2_axil_pkg::ST_WR_REQ:  state_d = l2_axil_pkg::ST_WR_RESP;
         l2_axil_pkg::ST_WR_RESP: if (bready_i) state_d = l2_axil_pkg::ST_IDLE;
         l2_axil_pkg::ST_RD_REQ:  state_d = l2_axil_pkg::ST_RD_WAIT;
         l2_axil_pkg::ST_RD_WAIT: if (bank_o.rvalid) state_d = l2_axil_pkg::ST_RD_RESP;
         l2_axil_pkg::ST_RD_RESP: if (rready_i) state_d = l2_axil_pkg::ST_IDLE;
         default:                 state_d = l2_axil_pkg::ST_INIT;
      endcase
   end

   always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
         state_q <= l2_axil_pkg::ST_INIT;
      end else begin
         state_q <= state_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_acc) begin
         addr_q  <= awaddr_i;
         wdata_q <= wdata_i;
         wstrb_q <= wstrb_i;
      end else if (rd_acc) begin
         addr_q  <= araddr_i;
      end
      // Decode of the held address is valid in the request cycle
      if (state_q inside {l2_axil_pkg::ST_WR_REQ, l2_axil_pkg::ST_RD_REQ}) begin
         resp_q <= resp_err_i ? l2_axil_pkg::RESP_DECERR : l2_axil_pkg::RESP_OKAY;
      end
      if (state_q == l2_axil_pkg::ST_RD_WAIT && bank_o.rvalid) begin
         rdata_q <= bank_o.rdata;
      end
   end

   // Sweep writes zero to the same word of every bank until the counter is done
   assign bank_o.req   = (in_init && !init_done_i) ||
                         (state_q == l2_axil_pkg::ST_WR_REQ) ||
                         (state_q == l2_axil_pkg::ST_RD_REQ);
   assign bank_o.op    = (state_q == l2_axil_pkg::ST_RD_REQ) ? l2_mem_pkg::OP_READ
                                                             : l2_mem_pkg::OP_WRITE;
   assign bank_o.add   = in_init ? 32'(init_index_i) : addr_q;   // Word index while sweeping
   assign bank_o.be    = in_init ? '1 : wstrb_q;
   assign bank_o.wdata = in_init ? '0 : wdata_q;
   assign broadcast_o  = in_init;

   assign bvalid_o = (state_q == l2_axil_pkg::ST_WR_RESP);
   assign bresp_o  = resp_q;
   assign rvalid_o = (state_q == l2_axil_pkg::ST_RD_RESP);
   assign rdata_o  = rdata_q;
   assign rresp_o  = resp_q;

   a_one_resp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(bvalid_o && rvalid_o));

   // Read data must survive any rready stall
   a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o));

endmodule

/* hw/l2_axil_pkg.sv */
// AXI4-Lite response codes and controller state encoding, referenced by scoped name
package l2_axil_pkg;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_DECERR = 2'b11   // No region behind the address
   } axil_resp_e;

   // One transaction in flight, reads and writes have separate paths
   typedef enum logic [2:0] {
      ST_INIT,      // Zeroing sweep, port closed
      ST_IDLE,
      ST_WR_REQ,
      ST_WR_RESP,
      ST_RD_REQ,
      ST_RD_WAIT,   // Bank answers here
      ST_RD_RESP
   } ctrl_state_e;

endpackage

/* hw/l2_bank_if.sv */
// Single-word bank request with its one-cycle response, used between controller, router and RAM
`timescale 1ns/1ps
`include "l2_mem_params.svh"

interface l2_bank_if;

   logic                           req;
   l2_mem_pkg::bank_op_e           op;
   logic [31:0]                    add;    // Byte address
   logic [`L2_DATA_WIDTH/8-1:0]    be;
   logic [`L2_DATA_WIDTH-1:0]      wdata;
   logic [`L2_DATA_WIDTH-1:0]      rdata;
   logic                           rvalid; // One cycle after req, for reads and writes

   modport master (
      output req, op, add, be, wdata,
      input  rdata, rvalid
   );

   modport slave (
      input  req, op, add, be, wdata,
      output rdata, rvalid
   );

endinterface

/* hw/l2_bank_router.sv */
// Region decode and fan-out of one bank request to the six banks, with merge of their responses
`timescale 1ns/1ps
`include "l2_mem_params.svh"

module l2_bank_router (
   input  logic           clk_i,
   input  logic           rst_ni,
   l2_bank_if.slave       up_i,
   input  logic           broadcast_i,
   l2_bank_if.master      banks_o [`L2_NB_BANKS+2],
   output logic           unmapped_o
);

   localparam int unsigned NB_PORTS   = `L2_NB_BANKS + 2;
   localparam int unsigned BANK_BITS  = $clog2(`L2_NB_BANKS);
   localparam logic [31:0] INTL_BYTES = `L2_NB_BANKS * `L2_INTL_WORDS * 4;
   localparam logic [31:0] PRI_BYTES  = `L2_PRI_WORDS * 4;

   l2_mem_pkg::region_e          region;
   logic [31:0]                  intl_off, pri0_off, pri1_off;
   logic [NB_PORTS-1:0]          sel;
   logic [NB_PORTS-1:0]          bank_req;
   logic [NB_PORTS-1:0]          bank_rvalid;
   logic [`L2_DATA_WIDTH-1:0]    bank_rdata [NB_PORTS];
   logic                         none_q;

   // Wrap-around subtraction makes each range check a single compare
   assign intl_off = up_i.add - `L2_INTL_START_ADDR;
   assign pri0_off = up_i.add - `L2_PRI0_START_ADDR;
   assign pri1_off = up_i.add - `L2_PRI1_START_ADDR;

   always_comb begin
      if (intl_off < INTL_BYTES) begin
         region = l2_mem_pkg::REG_INTL;
      end else if (pri0_off < PRI_BYTES) begin
         region = l2_mem_pkg::REG_PRI0;
      end else if (pri1_off < PRI_BYTES) begin
         region = l2_mem_pkg::REG_PRI1;
      end else begin
         region = l2_mem_pkg::REG_NONE;
      end
   end

   always_comb begin
      sel = '0;
      unique case (region)
         l2_mem_pkg::REG_INTL: sel[intl_off[2 +: BANK_BITS]] = 1'b1;   // Word interleaving
         l2_mem_pkg::REG_PRI0: sel[NB_PORTS-2] = 1'b1;
         l2_mem_pkg::REG_PRI1: sel[NB_PORTS-1] = 1'b1;
         default:              sel = '0;
      endcase
   end

   assign unmapped_o = (region == l2_mem_pkg::REG_NONE);

   for (genvar i = 0; i < NB_PORTS; i++) begin : g_port
      // In broadcast the upstream address is a word index, rebuilt per region here
      localparam logic [31:0] BASE = (i < `L2_NB_BANKS) ? `L2_INTL_START_ADDR :
                                     (i == `L2_NB_BANKS) ? `L2_PRI0_START_ADDR :
                                                           `L2_PRI1_START_ADDR;
      localparam int unsigned SHIFT = (i < `L2_NB_BANKS) ? 2 + BANK_BITS : 2;

      assign banks_o[i].req   = up_i.req && (broadcast_i || sel[i]);
      assign banks_o[i].op    = up_i.op;
      assign banks_o[i].add   = broadcast_i ? BASE + (up_i.add << SHIFT) : up_i.add;
      assign banks_o[i].be    = up_i.be;
      assign banks_o[i].wdata = up_i.wdata;
      assign bank_req[i]      = banks_o[i].req;
      assign bank_rvalid[i]   = banks_o[i].rvalid;
      assign bank_rdata[i]    = banks_o[i].rdata;
   end

   // Unmapped access gets its own zero answer so the controller never hangs
   always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
         none_q <= 1'b0;
      end else begin
         none_q <= up_i.req && !broadcast_i && (region == l2_mem_pkg::REG_NONE);
      end
   end

   always_comb begin
      up_i.rvalid = none_q;
      up_i.rdata  = '0;
      for (int k = 0; k < NB_PORTS; k++) begin
         up_i.rvalid = up_i.rvalid | bank_rvalid[k];
         if (bank_rvalid[k]) begin
            up_i.rdata = up_i.rdata | bank_rdata[k];
         end
      end
   end

   a_single_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
      broadcast_i || $onehot0(bank_req));

endmodule

/* hw/l2_init_counter.sv */
// Word index sweep after reset, drives the zeroing writes and signals when memory is clear
`timescale 1ns/1ps
`include "l2_mem_params.svh"

module l2_init_counter (
   input  logic                                 clk_i,
   input  logic                                 rst_ni,
   output logic [$clog2(`L2_INTL_WORDS)-1:0]    index_o,
   output logic                                 done_o
);

   localparam int unsigned IDX_W = $clog2(`L2_INTL_WORDS);

   // Private banks are shallower and wrap on the low index bits
   always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
         index_o <= '0;
         done_o  <= 1'b0;
      end else if (!done_o) begin
         if (index_o == IDX_W'(`L2_INTL_WORDS - 1)) begin
            done_o <= 1'b1;                 // Last word written this cycle
         end else begin
            index_o <= index_o + 1'b1;
         end
      end
   end

endmodule

/* hw/l2_mem_params.svh */
// Sizing and memory map macros of the L2 subsystem, included by the RTL that needs them
`ifndef L2_MEM_PARAMS_SVH
`define L2_MEM_PARAMS_SVH

// Interleaved region, four banks side by side
`define L2_NB_BANKS         4
`define L2_INTL_WORDS       64

// Each private bank
`define L2_PRI_WORDS        32

// Region bases, interleaved region spans 1 KiB, each private bank 128 bytes
`define L2_INTL_START_ADDR  32'h1000_0000
`define L2_PRI0_START_ADDR  32'h1000_1000
`define L2_PRI1_START_ADDR  32'h1000_2000

`define L2_DATA_WIDTH       32

`endif

/* hw/l2_mem_pkg.sv */
// Region decode and bank opcode types shared by the bank-side modules
package l2_mem_pkg;

   // Result of the address decode in the router
   typedef enum logic [1:0] {
      REG_INTL,
      REG_PRI0,
      REG_PRI1,
      REG_NONE   // Unmapped, answered with DECERR
   } region_e;

   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } bank_op_e;

endpackage

/* hw/l2_mem_subsys.sv */
// L2 memory subsystem top, one AXI4-Lite slave port in front of zeroed interleaved and private banks
`timescale 1ns/1ps
`include "l2_mem_params.svh"

module l2_mem_subsys (
   input  logic                           clk_i,
   input  logic                           rst_ni,
   input  logic                           awvalid_i,
   output logic                           awready_o,
   input  logic [31:0]                    awaddr_i,
   input  logic                           wvalid_i,
   output logic                           wready_o,
   input  logic [`L2_DATA_WIDTH-1:0]      wdata_i,
   input  logic [`L2_DATA_WIDTH/8-1:0]    wstrb_i,
   output logic                           bvalid_o,
   input  logic                           bready_i,
   output logic [1:0]                     bresp_o,
   input  logic                           arvalid_i,
   output logic                           arready_o,
   input  logic [31:0]                    araddr_i,
   output logic                           rvalid_o,
   input  logic                           rready_i,
   output logic [`L2_DATA_WIDTH-1:0]      rdata_o,
   output logic [1:0]                     rresp_o
);

   localparam int unsigned IDX_W = $clog2(`L2_INTL_WORDS);

   logic               init_done;
   logic [IDX_W-1:0]   init_index;
   logic               broadcast;
   logic               unmapped;

   l2_bank_if up_bus ();
   l2_bank_if bank_bus [`L2_NB_BANKS+2] ();   // Interleaved first, then PRI0 and PRI1

   l2_init_counter i_init_counter (
      .clk_i,
      .rst_ni,
      .index_o ( init_index ),
      .done_o  ( init_done  )
   );

   l2_axil_ctrl #(
      .IDX_W  ( IDX_W          ),
      .DATA_W ( `L2_DATA_WIDTH )
   ) i_ctrl (
      .clk_i,
      .rst_ni,
      .init_done_i  ( init_done  ),
      .init_index_i ( init_index ),
      .awvalid_i, .awready_o, .awaddr_i,
      .wvalid_i, .wready_o, .wdata_i, .wstrb_i,
      .bvalid_o, .bready_i, .bresp_o,
      .arvalid_i, .arready_o, .araddr_i,
      .rvalid_o, .rready_i, .rdata_o, .rresp_o,
      .bank_o       ( up_bus     ),
      .broadcast_o  ( broadcast  ),
      .resp_err_i   ( unmapped   )
   );

   l2_bank_router i_router (
      .clk_i,
      .rst_ni,
      .up_i        ( up_bus    ),
      .broadcast_i ( broadcast ),
      .banks_o     ( bank_bus  ),
      .unmapped_o  ( unmapped  )
   );

   l2_ram_multi_bank i_ram (
      .clk_i,
      .rst_ni,
      .mem_slave     ( bank_bus[0:`L2_NB_BANKS-1]            ),
      .mem_pri_slave ( bank_bus[`L2_NB_BANKS:`L2_NB_BANKS+1] )
   );

endmodule

/* hw/l2_ram_multi_bank.sv */
// Six L2 banks behind the router's bank interfaces that strip the region offset and answer after one cycle
`timescale 1ns/1ps
`include "l2_mem_params.svh"

module l2_ram_multi_bank (
   input  logic        clk_i,
   input  logic        rst_ni,
   l2_bank_if.slave    mem_slave     [`L2_NB_BANKS],
   l2_bank_if.slave    mem_pri_slave [2]
);

   localparam int unsigned BANK_BITS = $clog2(`L2_NB_BANKS);
   localparam int unsigned INTL_AW   = $clog2(`L2_INTL_WORDS);
   localparam int unsigned PRI_AW    = $clog2(`L2_PRI_WORDS);

   for (genvar i = 0; i < `L2_NB_BANKS; i++) begin : g_intl
      logic [31:0] offset;

      assign offset = mem_slave[i].add - `L2_INTL_START_ADDR;

      always_ff @(posedge clk_i, negedge rst_ni) begin
         if (!rst_ni) begin
            mem_slave[i].rvalid <= 1'b0;
         end else begin
            mem_slave[i].rvalid <= mem_slave[i].req;
         end
      end

      // Word index sits above the byte and bank select bits
      l2_sram_bank #(
         .WORDS   ( `L2_INTL_WORDS )
      ) i_bank (
         .clk_i   ( clk_i                                      ),
         .req_i   ( mem_slave[i].req                           ),
         .we_i    ( mem_slave[i].op == l2_mem_pkg::OP_WRITE    ),
         .be_i    ( mem_slave[i].be                            ),
         .addr_i  ( offset[2+BANK_BITS +: INTL_AW]             ),
         .wdata_i ( mem_slave[i].wdata                         ),
         .rdata_o ( mem_slave[i].rdata                         )
      );

      // A read answers one cycle later with a word the init sweep has written
      a_fixed_lat: assert property (@(posedge clk_i) disable iff (!rst_ni)
         mem_slave[i].req && mem_slave[i].op == l2_mem_pkg::OP_READ |=>
            mem_slave[i].rvalid && !$isunknown(mem_slave[i].rdata));
   end

   for (genvar p = 0; p < 2; p++) begin : g_pri
      localparam logic [31:0] BASE = (p == 0) ? `L2_PRI0_START_ADDR : `L2_PRI1_START_ADDR;
      logic [31:0] offset;

      assign offset = mem_pri_slave[p].add - BASE;

      always_ff @(posedge clk_i, negedge rst_ni) begin
         if (!rst_ni) begin
            mem_pri_slave[p].rvalid <= 1'b0;
         end else begin
            mem_pri_slave[p].rvalid <= mem_pri_slave[p].req;
         end
      end

      l2_sram_bank #(
         .WORDS   ( `L2_PRI_WORDS )
      ) i_bank (
         .clk_i   ( clk_i                                        ),
         .req_i   ( mem_pri_slave[p].req                         ),
         .we_i    ( mem_pri_slave[p].op == l2_mem_pkg::OP_WRITE  ),
         .be_i    ( mem_pri_slave[p].be                          ),
         .addr_i  ( offset[2 +: PRI_AW]                          ),   // Byte to word
         .wdata_i ( mem_pri_slave[p].wdata                       ),
         .rdata_o ( mem_pri_slave[p].rdata                       )
      );

      a_fixed_lat: assert property (@(posedge clk_i) disable iff (!rst_ni)
         mem_pri_slave[p].req && mem_pri_slave[p].op == l2_mem_pkg::OP_READ |=>
            mem_pri_slave[p].rvalid && !$isunknown(mem_pri_slave[p].rdata));
   end

endmodule

/* hw/l2_sram_bank.sv */
// Behavioral single-port word memory with byte enables, read data registered one cycle after req
`timescale 1ns/1ps
`include "l2_mem_params.svh"

module l2_sram_bank #(
   parameter int unsigned WORDS = 64
) (
   input  logic                           clk_i,
   input  logic                           req_i,
   input  logic                           we_i,
   input  logic [`L2_DATA_WIDTH/8-1:0]    be_i,
   input  logic [$clog2(WORDS)-1:0]       addr_i,
   input  logic [`L2_DATA_WIDTH-1:0]      wdata_i,
   output logic [`L2_DATA_WIDTH-1:0]      rdata_o
);

   logic [`L2_DATA_WIDTH-1:0] mem [WORDS];

   always_ff @(posedge clk_i) begin
      if (req_i) begin
         if (we_i) begin
            for (int b = 0; b < `L2_DATA_WIDTH/8; b++) begin
               if (be_i[b]) begin
                  mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
               end
            end
         end else begin
            rdata_o <= mem[addr_i];   // Holds between reads
         end
      end
   end

endmodule

/* l2_mem_subsys.f */
+incdir+hw
hw/l2_axil_pkg.sv
hw/l2_mem_pkg.sv
hw/l2_bank_if.sv
hw/l2_sram_bank.sv
hw/l2_ram_multi_bank.sv
hw/l2_init_counter.sv
hw/l2_bank_router.sv
hw/l2_axil_ctrl.sv
hw/l2_mem_subsys.sv
verif/tb_l2_mem_subsys.sv

/* verif/l2_mem_vectors.txt */
# op addr wdata strb exp_rdata exp_resp, hex; W and R plain, w and r with bready/rready stalls
# exp_resp 0 is OKAY and 3 is DECERR
R 10000000 00000000 0 00000000 0
R 1000000c 00000000 0 00000000 0
R 100003fc 00000000 0 00000000 0
R 1000107c 00000000 0 00000000 0
R 10002040 00000000 0 00000000 0
W 10000010 a1a1a1a1 f 00000000 0
W 10000014 b2b2b2b2 f 00000000 0
W 10000018 c3c3c3c3 f 00000000 0
R 10000010 00000000 0 a1a1a1a1 0
R 10000014 00000000 0 b2b2b2b2 0
R 10000018 00000000 0 c3c3c3c3 0
W 10000014 11223344 5 00000000 0
R 10000014 00000000 0 b222b244 0
W 10001010 0badf00d f 00000000 0
W 10002010 600dcafe f 00000000 0
R 10001010 00000000 0 0badf00d 0
R 10002010 00000000 0 600dcafe 0
R 10000010 00000000 0 a1a1a1a1 0
W 10000400 deadbeef f 00000000 3
W 10001080 deadbeef f 00000000 3
R 10000400 00000000 0 00000000 3
R 10001000 00000000 0 00000000 0
w 10002004 12345678 f 00000000 0
r 10002004 00000000 0 12345678 0
r 10000014 00000000 0 b222b244 0
r 10003000 00000000 0 00000000 3

/* verif/tb_l2_mem_subsys.sv */
// Self-checking testbench of the L2 subsystem that replays the vector file over the AXI4-Lite port
`timescale 1ns/1ps
`include "l2_mem_params.svh"

module tb_l2_mem_subsys;

   localparam time         CLK_PERIOD  = 100ns;
   localparam time         DRIVE_DELAY = 10ns;
   localparam int          RST_CYCLES  = 4;
   localparam int          INIT_CYCLES = RST_CYCLES + `L2_INTL_WORDS + 1;
   localparam int          LINE_CYCLES = 20;   // Worst case per transaction incl. 7 stall cycles
   localparam logic [31:0] INTL_BYTES  = `L2_NB_BANKS * `L2_INTL_WORDS * 4;
   localparam logic [31:0] PRI_BYTES   = `L2_PRI_WORDS * 4;
   localparam int          MODEL_WORDS = `L2_NB_BANKS * `L2_INTL_WORDS + 2 * `L2_PRI_WORDS;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        awvalid, awready, wvalid, wready, bvalid, bready;
   logic        arvalid, arready, rvalid, rready;
   logic [31:0] awaddr, araddr, wdata, rdata;
   logic [3:0]  wstrb;
   logic [1:0]  bresp, rresp;

   byte         vec_op [$];
   logic [31:0] vec_addr [$];
   logic [31:0] vec_wdata [$];
   logic [3:0]  vec_strb [$];
   logic [31:0] vec_rdata [$];
   logic [1:0]  vec_resp [$];

   logic [31:0] model_mem [MODEL_WORDS];   // Interleaved words, then PRI0, then PRI1
   logic [15:0] lfsr_state;
   int          cycles      = 0;
   int          cycle_limit = INIT_CYCLES + LINE_CYCLES;
   int          release_cycle;
   int          line_errs;

   l2_mem_subsys i_dut (
      .clk_i     ( clk     ),
      .rst_ni    ( rst_n   ),
      .awvalid_i ( awvalid ), .awready_o ( awready ), .awaddr_i ( awaddr ),
      .wvalid_i  ( wvalid  ), .wready_o  ( wready  ), .wdata_i  ( wdata  ), .wstrb_i ( wstrb ),
      .bvalid_o  ( bvalid  ), .bready_i  ( bready  ), .bresp_o  ( bresp  ),
      .arvalid_i ( arvalid ), .arready_o ( arready ), .araddr_i ( araddr ),
      .rvalid_o  ( rvalid  ), .rready_i  ( rready  ), .rdata_o  ( rdata  ), .rresp_o ( rresp )
   );

   always #(CLK_PERIOD/2) clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("Timeout after %0d cycles, a handshake never completed", cycles);
         $display(">>> FAIL");
         $finish;
      end
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic pick_stall(output int n);
      n = 0;
      for (int k = 0; k < 3; k++) begin
         lfsr_state = lfsr_next(lfsr_state);   // One step per bit
         n = (n << 1) | lfsr_state[0];
      end
   endtask

   // Word slot in the model or -1 outside every region
   function automatic int model_index(input logic [31:0] a);
      if (a >= `L2_INTL_START_ADDR && a < `L2_INTL_START_ADDR + INTL_BYTES) begin
         return int'((a - `L2_INTL_START_ADDR) >> 2);
      end
      if (a >= `L2_PRI0_START_ADDR && a < `L2_PRI0_START_ADDR + PRI_BYTES) begin
         return `L2_NB_BANKS * `L2_INTL_WORDS + int'((a - `L2_PRI0_START_ADDR) >> 2);
      end
      if (a >= `L2_PRI1_START_ADDR && a < `L2_PRI1_START_ADDR + PRI_BYTES) begin
         return MODEL_WORDS - `L2_PRI_WORDS + int'((a - `L2_PRI1_START_ADDR) >> 2);
      end
      return -1;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                               input logic [3:0] strb);
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

   // One AXI4-Lite transaction with an optional random stall on bready or rready
   task automatic run_txn(input logic is_wr, input logic stalled, input logic [31:0] addr,
                          input logic [31:0] data, input logic [3:0] strb,
                          output logic [31:0] got_data, output logic [1:0] got_resp);
      int    lat;
      int    stall;
      int    exp_lat;
      string vname;
      stall   = 0;
      exp_lat = is_wr ? 2 : 3;
      vname   = is_wr ? "bvalid_o" : "rvalid_o";
      if (stalled) pick_stall(stall);
      if (is_wr) begin
         awaddr  = addr;
         wdata   = data;
         wstrb   = strb;
         awvalid = 1'b1;
         wvalid  = 1'b1;
         bready  = !stalled;
      end else begin
         araddr  = addr;
         arvalid = 1'b1;
         rready  = !stalled;
      end
      @(negedge clk);
      while (!(is_wr ? awready : arready)) begin
         @(negedge clk);
      end
      if (is_wr && !wready) begin   // Address and data are taken in the same cycle
         $display("ERR t=%0t wready_o exp=1 got=%0b", $time, wready);
         line_errs++;
      end
      if (cycles - release_cycle < `L2_INTL_WORDS + 1) begin   // Port must stay closed during sweep
         $display("ERR t=%0t %s open after %0d cycles, exp>=%0d", $time,
                  is_wr ? "awready_o" : "arready_o", cycles - release_cycle, `L2_INTL_WORDS + 1);
         line_errs++;
      end
      @(posedge clk);
      #DRIVE_DELAY;
      awvalid = 1'b0;
      wvalid  = 1'b0;
      arvalid = 1'b0;
      lat = 1;
      @(negedge clk);
      while (!(is_wr ? bvalid : rvalid)) begin
         @(negedge clk);
         lat++;
      end
      if (lat != exp_lat) begin
         $display("ERR t=%0t %s latency exp=%0d got=%0d", $time, vname, exp_lat, lat);
         line_errs++;
      end
      got_resp = is_wr ? bresp : rresp;
      got_data = is_wr ? 32'h0 : rdata;
      repeat (stall) begin
         @(posedge clk);
         #DRIVE_DELAY;
         @(negedge clk);
         if (!(is_wr ? bvalid : rvalid)) begin
            $display("ERR t=%0t %s exp=1 got=0", $time, vname);
            line_errs++;
         end
         if ((is_wr ? bresp : rresp) != got_resp) begin
            $display("ERR t=%0t %s exp=%0h got=%0h", $time, is_wr ? "bresp_o" : "rresp_o",
                     got_resp, is_wr ? bresp : rresp);
            line_errs++;
         end
         if (!is_wr && rdata != got_data) begin
            $display("ERR t=%0t rdata_o exp=%08h got=%08h", $time, got_data, rdata);
            line_errs++;
         end
      end
      if (stalled) begin
         @(posedge clk);
         #DRIVE_DELAY;
         bready = is_wr;
         rready = !is_wr;
      end
      @(posedge clk);   // Response taken here
      #DRIVE_DELAY;
      bready = 1'b0;
      rready = 1'b0;
   endtask

   initial begin
      int          fd;
      int          idx;
      int          n_pass;
      int          n_fail;
      string       line;
      byte         op;
      logic [31:0] a, d, e;
      logic [3:0]  s;
      logic [1:0]  r;
      logic        wr;
      logic        stl;
      logic [31:0] got_d, ref_d;
      logic [1:0]  got_r, ref_r;

      rst_n   = 1'b0;
      awvalid = 1'b0;
      awaddr  = '0;
      wvalid  = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      bready  = 1'b0;
      arvalid = 1'b0;
      araddr  = '0;
      rready  = 1'b0;
      lfsr_state = 16'd55157;
      n_pass = 0;
      n_fail = 0;
      for (int k = 0; k < MODEL_WORDS; k++) model_mem[k] = '0;   // Zeroed after reset

      fd = $fopen("verif/l2_mem_vectors.txt", "r");
      if (fd == 0) $display("Cannot open the vector file verif/l2_mem_vectors.txt");
      while (fd != 0 && !$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 0 && line[0] != "#" &&
             $sscanf(line, "%c %h %h %h %h %h", op, a, d, s, e, r) == 6) begin
            vec_op.push_back(op);
            vec_addr.push_back(a);
            vec_wdata.push_back(d);
            vec_strb.push_back(s);
            vec_rdata.push_back(e);
            vec_resp.push_back(r);
         end
      end
      if (fd != 0) $fclose(fd);
      cycle_limit = INIT_CYCLES + LINE_CYCLES * vec_op.size();

      repeat (RST_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst_n = 1'b1;
      release_cycle = cycles;

      for (int i = 0; i < vec_op.size(); i++) begin
         wr  = (vec_op[i] == "W" || vec_op[i] == "w");
         stl = (vec_op[i] == "w" || vec_op[i] == "r");   // Lower case lines get back-pressure
         line_errs = 0;
         idx   = model_index(vec_addr[i]);
         ref_r = (idx < 0) ? l2_axil_pkg::RESP_DECERR : l2_axil_pkg::RESP_OKAY;
         ref_d = (wr || idx < 0) ? 32'h0 : model_mem[idx];
         if (vec_resp[i] != ref_r || (!wr && vec_rdata[i] != ref_d)) begin
            $display("Vector %0d does not agree with the memory model", i);
            line_errs++;
         end
         run_txn(wr, stl, vec_addr[i], vec_wdata[i], vec_strb[i], got_d, got_r);
         if (got_r != vec_resp[i]) begin
            $display("ERR t=%0t %s exp=%0h got=%0h", $time, wr ? "bresp_o" : "rresp_o",
                     vec_resp[i], got_r);
            line_errs++;
         end
         if (!wr && got_d != vec_rdata[i]) begin
            $display("ERR t=%0t rdata_o exp=%08h got=%08h", $time, vec_rdata[i], got_d);
            line_errs++;
         end
         if (wr && idx >= 0) model_mem[idx] = merge_bytes(model_mem[idx], vec_wdata[i],
                                                          vec_strb[i]);
         if (line_errs == 0) n_pass++;
         else n_fail++;
         $display("Test %0d %s %08h %s", i, wr ? "write" : "read", vec_addr[i],
                  (line_errs == 0) ? "ok" : "failed");
      end

      $display("Tests run %0d, passed %0d, failed %0d", vec_op.size(), n_pass, n_fail);
      if (n_fail == 0 && vec_op.size() > 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule
